// File: logic/controlDecoder.sv
// ----------------------------------------
// datapath strobe and select decode from
// the current state, class and flags
// ----------------------------------------
`timescale 1ns/1ps

module controlDecoder import isaPkg::*, controlPkg::*;
(
	input  cycleStateT state,
	input  instrClassT instrClass,
	input  logic       negative,
	input  logic       zero,
	output logic       pcWrite,
	output logic       addrSel,
	output logic       memRead,
	output logic       memWrite,
	output logic       irLoad,
	output logic       r1Sel,
	output logic       mdrLoad,
	output logic       r1Load,
	output logic       r2Load,
	output logic       aluSrcA,
	output aluOpT      aluOp,
	output aluSrcBT    aluSrcB,
	output logic       aluOutWrite,
	output logic       rfWrite,
	output logic       regIn,
	output logic       flagWrite
);

	always_comb
	begin
		// everything inactive unless the state raises it
		pcWrite     = 1'b0;
		addrSel     = 1'b0;
		memRead     = 1'b0;
		memWrite    = 1'b0;
		irLoad      = 1'b0;
		r1Sel       = 1'b0;
		mdrLoad     = 1'b0;
		r1Load      = 1'b0;
		r2Load      = 1'b0;
		aluSrcA     = 1'b0;
		aluOp       = aluAdd;
		aluSrcB     = srcBReg;
		aluOutWrite = 1'b0;
		rfWrite     = 1'b0;
		regIn       = 1'b0;
		flagWrite   = 1'b0;

		case (state)
			stFetch:
			begin
				pcWrite = 1'b1;  // pc + 1
				addrSel = 1'b1;
				memRead = 1'b1;
				irLoad  = 1'b1;
				aluSrcB = srcBOne;
			end
			stDecode:
			begin
				r1Load = 1'b1;
				r2Load = 1'b1;
			end
			stAluExec:
			begin
				aluSrcA     = 1'b1;
				aluOutWrite = 1'b1;
				flagWrite   = 1'b1;
				case (instrClass)
					clsSub:  aluOp = aluSub;
					clsNand: aluOp = aluNand;
					default: aluOp = aluAdd;
				endcase
			end
			stShiftExec:
			begin
				aluSrcA     = 1'b1;
				aluOp       = aluShift;
				aluSrcB     = srcBShift;
				aluOutWrite = 1'b1;
				flagWrite   = 1'b1;
			end
			stOriReadSrc:
			begin
				r1Sel  = 1'b1;
				r1Load = 1'b1;
				r2Load = 1'b1;
			end
			stOriExec:
			begin
				aluSrcA     = 1'b1;
				aluOp       = aluOr;
				aluSrcB     = srcBImm;
				aluOutWrite = 1'b1;
				flagWrite   = 1'b1;
			end
			stOriWriteback:
			begin
				r1Sel   = 1'b1;
				rfWrite = 1'b1;
			end
			stLoadRead:
			begin
				memRead = 1'b1;
				mdrLoad = 1'b1;
			end
			stLoadWriteback:
			begin
				aluOutWrite = 1'b1;
				rfWrite     = 1'b1;
				regIn       = 1'b1;  // write back from mdr
			end
			stRegWriteback: rfWrite = 1'b1;
			stStoreWrite:   memWrite = 1'b1;

			// ----------------------------------------
			// conditional branches
			// ----------------------------------------
			stBranchBpz:
			begin
				pcWrite = ~negative;
				aluSrcB = srcBOffset;
			end
			stBranchBz:
			begin
				pcWrite = zero;
				aluSrcB = srcBOffset;
			end
			stBranchBnz:
			begin
				pcWrite = ~zero;
				aluSrcB = srcBOffset;
			end
			default: ;  // idle and halted drive nothing
		endcase
	end

endmodule

// File: logic/controlPkg.sv
// ----------------------------------------
// sequencer state type
// ----------------------------------------
`include "controlUnit_macros.svh"

package controlPkg;

	// ----------------------------------------
	// one state per cycle of each instruction
	// ----------------------------------------
	typedef enum logic [`STATE_WIDTH-1:0]
	{
		stIdle          = 5'd0,
		stFetch         = 5'd1,
		stDecode        = 5'd2,
		stAluExec       = 5'd3,   // add, sub, nand
		stRegWriteback  = 5'd4,   // shared with shift
		stShiftExec     = 5'd5,
		stOriReadSrc    = 5'd6,
		stOriExec       = 5'd7,
		stOriWriteback  = 5'd8,
		stLoadRead      = 5'd9,
		stLoadWriteback = 5'd10,
		stStoreWrite    = 5'd11,
		stBranchBpz     = 5'd12,
		stBranchBz      = 5'd13,
		stBranchBnz     = 5'd14,
		stHalted        = 5'd15
	} cycleStateT;

endpackage

// File: logic/controlUnit.sv
// ----------------------------------------
// control unit top: opcode decode, state
// sequencer and strobe decode
// ----------------------------------------
`timescale 1ns/1ps
`include "controlUnit_macros.svh"

module controlUnit import isaPkg::*, controlPkg::*;
(
	input  logic                     clock,
	input  logic                     reset,
	input  logic [`OPCODE_WIDTH-1:0] instr,
	input  logic                     negative,
	input  logic                     zero,
	input  logic                     resume,
	output logic                     pcWrite,
	output logic                     addrSel,
	output logic                     memRead,
	output logic                     memWrite,
	output logic                     irLoad,
	output logic                     r1Sel,
	output logic                     mdrLoad,
	output logic                     r1Load,
	output logic                     r2Load,
	output logic                     aluSrcA,
	output aluOpT                    aluOp,
	output aluSrcBT                  aluSrcB,
	output logic                     aluOutWrite,
	output logic                     rfWrite,
	output logic                     regIn,
	output logic                     flagWrite
);

	instrClassT instrClass;
	cycleStateT state;

	opcodeDecoder opcodeDecoder_i
	(
		.instr      (opcodeT'(instr)),
		.instrClass (instrClass)
	);

	stateSequencer stateSequencer_i
	(
		.clock      (clock),
		.reset      (reset),
		.instrClass (instrClass),
		.resume     (resume),
		.state      (state)
	);

	controlDecoder controlDecoder_i
	(
		.state       (state),
		.instrClass  (instrClass),
		.negative    (negative),
		.zero        (zero),
		.pcWrite     (pcWrite),
		.addrSel     (addrSel),
		.memRead     (memRead),
		.memWrite    (memWrite),
		.irLoad      (irLoad),
		.r1Sel       (r1Sel),
		.mdrLoad     (mdrLoad),
		.r1Load      (r1Load),
		.r2Load      (r2Load),
		.aluSrcA     (aluSrcA),
		.aluOp       (aluOp),
		.aluSrcB     (aluSrcB),
		.aluOutWrite (aluOutWrite),
		.rfWrite     (rfWrite),
		.regIn       (regIn),
		.flagWrite   (flagWrite)
	);

endmodule

// File: logic/controlUnit_macros.svh
// ----------------------------------------
// field and encoding widths of the control unit
// ----------------------------------------

`ifndef CONTROL_UNIT_MACROS_SVH
`define CONTROL_UNIT_MACROS_SVH

// instruction opcode field
`define OPCODE_WIDTH 4

// ALU function and B-operand select codes
`define ALU_OP_WIDTH 3
`define ALU_SRC_B_WIDTH 3

// sequencer state register
`define STATE_WIDTH 5

`endif

// File: logic/isaPkg.sv
// ----------------------------------------
// instruction set types: opcodes, decoded classes,
// ALU functions and ALU B-operand selects
// ----------------------------------------
`include "controlUnit_macros.svh"

package isaPkg;

	// shift and ori only fix the low three bits, these are their canonical codes
	typedef enum logic [`OPCODE_WIDTH-1:0]
	{
		opLoad  = 4'b0000,
		opStop  = 4'b0001,
		opStore = 4'b0010,
		opShift = 4'b0011,
		opAdd   = 4'b0100,
		opBz    = 4'b0101,
		opSub   = 4'b0110,
		opOri   = 4'b0111,
		opNand  = 4'b1000,
		opBnz   = 4'b1001,
		opBpz   = 4'b1101
	} opcodeT;

	localparam logic [2:0] shiftSuffix = 3'b011;
	localparam logic [2:0] oriSuffix   = 3'b111;

	// clsAdd, clsSub and clsNand form the register ALU group
	typedef enum logic [3:0]
	{
		clsAdd, clsSub, clsNand, clsShift, clsOri, clsLoad,
		clsStore, clsBpz, clsBz, clsBnz, clsStop, clsIllegal
	} instrClassT;

	typedef enum logic [`ALU_OP_WIDTH-1:0]
	{
		aluAdd = 3'b000, aluSub = 3'b001, aluOr = 3'b010, aluNand = 3'b011, aluShift = 3'b100
	} aluOpT;

	typedef enum logic [`ALU_SRC_B_WIDTH-1:0]
	{
		srcBReg    = 3'b000,
		srcBOne    = 3'b001,  // pc increment
		srcBOffset = 3'b010,
		srcBImm    = 3'b011,  // zero-extended
		srcBShift  = 3'b100
	} aluSrcBT;

endpackage

// File: logic/opcodeDecoder.sv
// ----------------------------------------
// opcode to instruction class decoder
// ----------------------------------------
`timescale 1ns/1ps

module opcodeDecoder import isaPkg::*;
(
	input  opcodeT     instr,
	output instrClassT instrClass
);

	// priority order matters, e.g. 0011 is shift before anything else
	always_comb
	begin
		if (instr == opAdd)
			instrClass = clsAdd;
		else if (instr == opSub)
			instrClass = clsSub;
		else if (instr == opNand)
			instrClass = clsNand;
		else if (instr[2:0] == shiftSuffix)
			instrClass = clsShift;
		else if (instr[2:0] == oriSuffix)
			instrClass = clsOri;
		else if (instr == opLoad)
			instrClass = clsLoad;
		else if (instr == opStore)
			instrClass = clsStore;
		else if (instr == opBpz)
			instrClass = clsBpz;
		else if (instr == opBz)
			instrClass = clsBz;
		else if (instr == opBnz)
			instrClass = clsBnz;
		else if (instr == opStop)
			instrClass = clsStop;
		else
			instrClass = clsIllegal;  // 1010, 1100, 1110
	end

endmodule

// File: logic/stateSequencer.sv
// ----------------------------------------
// state register and next-state logic
// ----------------------------------------
`timescale 1ns/1ps

module stateSequencer import isaPkg::*, controlPkg::*;
(
	input  logic       clock,
	input  logic       reset,
	input  instrClassT instrClass,
	input  logic       resume,
	output cycleStateT state
);

	cycleStateT nextState;

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
			state <= stIdle;
		else
			state <= nextState;
	end

	// ----------------------------------------
	// next state
	// ----------------------------------------
	always_comb
	begin
		nextState = stIdle;
		case (state)
			stIdle:   nextState = stFetch;
			stFetch:  nextState = stDecode;
			stDecode:
			begin
				case (instrClass)
					clsAdd, clsSub, clsNand: nextState = stAluExec;
					clsShift: nextState = stShiftExec;
					clsOri:   nextState = stOriReadSrc;
					clsLoad:  nextState = stLoadRead;
					clsStore: nextState = stStoreWrite;
					clsBpz:   nextState = stBranchBpz;
					clsBz:    nextState = stBranchBz;
					clsBnz:   nextState = stBranchBnz;
					clsStop:  nextState = stHalted;
					default:  nextState = stIdle;  // unknown opcode
				endcase
			end
			stAluExec:       nextState = stRegWriteback;
			stShiftExec:     nextState = stRegWriteback;
			stOriReadSrc:    nextState = stOriExec;
			stOriExec:       nextState = stOriWriteback;
			stLoadRead:      nextState = stLoadWriteback;
			stHalted:
			begin
				if (resume)
					nextState = stFetch;
				else
					nextState = stHalted;
			end
			// last execute cycle of every instruction
			stRegWriteback, stOriWriteback, stLoadWriteback, stStoreWrite,
			stBranchBpz, stBranchBz, stBranchBnz:
				nextState = stFetch;
			default: nextState = stIdle;
		endcase
	end

endmodule

// File: run.sh
#!/usr/bin/env bash
# build and run the control unit testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -f verilog.f --top-module controlUnitTb -o controlUnitSim \
	&& ./obj_dir/controlUnitSim +verilator+error+limit+1000 > sim.log 2>&1 \
	|| echo "RESULT: FAIL" >> sim.log

cat sim.log
! grep -q "RESULT: FAIL" sim.log

// File: sim/controlUnitTb.sv
// ----------------------------------------
// control unit testbench: clock, reset,
// random instruction stream and watchdog
// ----------------------------------------
`timescale 1ns/1ps
`include "controlUnit_macros.svh"

module controlUnitTb;

	localparam int clockPeriod    = 100;
	localparam int resetCycles    = 3;
	localparam int opcodeCount    = 16;
	localparam int totalInstrs    = opcodeCount + 200;  // every opcode, then random ones
	localparam int watchdogCycles = (totalInstrs + 1) * 10 + resetCycles;

	logic                       clock;
	logic                       reset;
	logic [`OPCODE_WIDTH-1:0]   instr;
	logic                       negative;
	logic                       zero;
	logic                       resume;
	logic                       pcWrite, addrSel, memRead, memWrite, irLoad, r1Sel;
	logic                       mdrLoad, r1Load, r2Load, aluSrcA, aluOutWrite;
	logic                       rfWrite, regIn, flagWrite;
	logic [`ALU_OP_WIDTH-1:0]   aluOp;
	logic [`ALU_SRC_B_WIDTH-1:0] aluSrcB;

	integer      seed = 32'h35aa7689;
	logic [31:0] randomWord;
	logic        fetchSeen = 1'b0;
	logic        stopActive;
	int          lowLeft;    // halted cycles still to hold resume low
	int          fetches;

	controlUnit dut_i (.*);

	initial
		clock = 1'b0;
	always #(clockPeriod / 2) clock = ~clock;

	always @(negedge clock)
		fetchSeen <= irLoad;  // settled mid-cycle

	// ----------------------------------------
	// stimulus
	// ----------------------------------------
	initial
	begin
		reset      = 1'b1;
		instr      = '0;
		negative   = 1'b0;
		zero       = 1'b0;
		resume     = 1'b0;
		stopActive = 1'b0;
		lowLeft    = 0;
		fetches    = 0;
		repeat (resetCycles) @(posedge clock);
		#1 reset = 1'b0;

		while (fetches <= totalInstrs)
		begin
			@(posedge clock);
			#1;
			randomWord = $random(seed);
			negative   = randomWord[0];
			zero       = randomWord[1];
			if (stopActive)
			begin
				resume     = (lowLeft == 0);
				stopActive = (lowLeft > 0);
				lowLeft    = lowLeft - 1;
			end
			else
				resume = randomWord[2];

			// new opcode only in the cycle after a fetch
			if (fetchSeen)
			begin
				if (fetches < totalInstrs)
				begin
					if (fetches < opcodeCount)
						instr = fetches[3:0];
					else
						instr = randomWord[7:4];
					if (instr == 4'b0001)
					begin
						stopActive = 1'b1;
						lowLeft    = randomWord % 6;
						resume     = 1'b0;
					end
				end
				fetches++;
			end
		end

		repeat (2) @(posedge clock);
		#1;
		$display("assertion failures: %0d", dut_i.checks_i.failCount);
		if (dut_i.checks_i.failCount == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

	initial
	begin
		#(watchdogCycles * clockPeriod);
		$display("timeout: instruction stream not finished after %0d cycles", watchdogCycles);
		$display("RESULT: FAIL");
		$finish;
	end

endmodule

// File: sim/controlUnit_asserts.sv
// ----------------------------------------
// bound checks on instruction cycle spacing,
// strobe values and halted behavior
// ----------------------------------------
`timescale 1ns/1ps
`include "controlUnit_macros.svh"

module controlUnitChecks import isaPkg::*;
(
	input logic                     clock, reset, negative, zero, resume,
	input logic [`OPCODE_WIDTH-1:0] instr,
	input logic                     pcWrite, addrSel, memRead, memWrite, irLoad, r1Sel,
	input logic                     mdrLoad, r1Load, r2Load, aluSrcA, aluOutWrite,
	input logic                     rfWrite, regIn, flagWrite,
	input aluOpT                    aluOp,
	input aluSrcBT                  aluSrcB
);

	int    failCount = 0;
	int    gap;        // cycles since the last irLoad
	int    lowCycles;  // halted cycles seen with resume low
	int    expectedGap;
	logic  seen;       // a fetch has happened since reset
	logic  quiet, isAluReg, isShift, isOri, isLoad, isStore, isBranch, isStop;
	logic  halted, takeBranch;
	aluOpT expectedOp;

	task automatic recordFailure(input string msg);
		failCount++;
		$error("%s", msg);
	endtask

	assign quiet = !(pcWrite | addrSel | memRead | memWrite | irLoad | r1Sel | mdrLoad
		| r1Load | r2Load | aluSrcA | aluOutWrite | rfWrite | regIn | flagWrite)
		&& aluOp == aluAdd && aluSrcB == srcBReg;

	// ----------------------------------------
	// expected behavior from the opcode
	// ----------------------------------------
	assign isAluReg   = instr == 4'b0100 || instr == 4'b0110 || instr == 4'b1000;
	assign isShift    = instr[2:0] == 3'b011;
	assign isOri      = instr[2:0] == 3'b111;
	assign isLoad     = instr == 4'b0000;
	assign isStore    = instr == 4'b0010;
	assign isBranch   = instr == 4'b1101 || instr == 4'b0101 || instr == 4'b1001;
	assign isStop     = instr == 4'b0001;
	assign halted     = seen && isStop && gap >= 2 && lowCycles == gap - 2;
	assign takeBranch = (instr == 4'b1101) ? !negative : ((instr == 4'b0101) ? zero : !zero);
	assign expectedOp = (instr == 4'b0110) ? aluSub : ((instr == 4'b1000) ? aluNand : aluAdd);

	always_comb
	begin
		if (isAluReg || isShift || isLoad)
			expectedGap = 4;
		else if (isOri)
			expectedGap = 5;
		else if (isStop)
			expectedGap = 3 + lowCycles;
		else
			expectedGap = 3;  // store, branches, illegal
	end

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			gap       <= 0;
			lowCycles <= 0;
			seen      <= 1'b0;
		end
		else if (irLoad)
		begin
			gap       <= 1;
			lowCycles <= 0;
			seen      <= 1'b1;
		end
		else
		begin
			gap <= gap + 1;
			if (halted && !resume)
				lowCycles <= lowCycles + 1;
		end
	end

	// ----------------------------------------
	// assertions
	// ----------------------------------------
	assert property (@(posedge clock) reset || $fell(reset) |-> quiet)
		else recordFailure("strobes active during reset or the cycle after it");
	assert property (@(posedge clock) $fell(reset) |=> irLoad)
		else recordFailure("no fetch one cycle after reset was released");
	assert property (@(posedge clock) disable iff (reset)
		irLoad |-> pcWrite && addrSel && memRead && aluSrcB == srcBOne)
		else recordFailure("fetch cycle without pc increment and instruction read");
	assert property (@(posedge clock) disable iff (reset)
		seen && gap == 1 |-> r1Load && r2Load)
		else recordFailure("decode cycle without register operand loads");
	assert property (@(posedge clock) disable iff (reset) seen && irLoad |-> gap == expectedGap)
		else recordFailure($sformatf("Mismatch spacing: expected %0d, actual %0d",
			$sampled(expectedGap), $sampled(gap)));
	assert property (@(posedge clock) disable iff (reset)
		seen && gap == 2 && (isAluReg || isShift) |-> aluSrcA && aluOutWrite && flagWrite)
		else recordFailure("ALU execute cycle without aluSrcA, aluOutWrite and flagWrite");
	assert property (@(posedge clock) disable iff (reset)
		seen && gap == 2 && isAluReg |-> aluOp == expectedOp)
		else recordFailure($sformatf("Mismatch aluOp: expected %b, actual %b",
			$sampled(expectedOp), $sampled(aluOp)));
	assert property (@(posedge clock) disable iff (reset)
		seen && gap == 2 && isShift |-> aluOp == aluShift && aluSrcB == srcBShift)
		else recordFailure("shift execute cycle without shift operation and shift amount");
	assert property (@(posedge clock) disable iff (reset)
		seen && gap == 2 && isBranch |-> pcWrite == takeBranch && aluSrcB == srcBOffset)
		else recordFailure($sformatf("Mismatch branch: expected pcWrite %b, actual %b",
			$sampled(takeBranch), $sampled(pcWrite)));
	assert property (@(posedge clock) disable iff (reset)
		memWrite == (seen && isStore && gap == 2))
		else recordFailure($sformatf("Mismatch memWrite: expected %b, actual %b",
			$sampled(seen && isStore && gap == 2), $sampled(memWrite)));
	assert property (@(posedge clock) disable iff (reset)
		seen && isLoad && gap == 2 |-> memRead && mdrLoad)
		else recordFailure("load read cycle without memRead and mdrLoad");
	assert property (@(posedge clock) disable iff (reset)
		seen && isLoad && gap == 3 |-> rfWrite && regIn)
		else recordFailure("load writeback cycle without rfWrite and regIn");
	assert property (@(posedge clock) disable iff (reset)
		seen && isOri && gap == 3 |-> aluOp == aluOr && aluSrcB == srcBImm)
		else recordFailure("ori execute cycle without or operation and immediate operand");
	assert property (@(posedge clock) disable iff (reset)
		seen && isOri && gap == 4 |-> rfWrite && r1Sel)
		else recordFailure("ori final cycle without rfWrite and r1Sel");
	assert property (@(posedge clock) disable iff (reset) halted |-> quiet)
		else recordFailure("strobes active while halted");

endmodule

bind controlUnit controlUnitChecks checks_i (.*);

// File: verilog.f
+incdir+logic
logic/isaPkg.sv
logic/controlPkg.sv
logic/opcodeDecoder.sv
logic/stateSequencer.sv
logic/controlDecoder.sv
logic/controlUnit.sv
sim/controlUnit_asserts.sv
sim/controlUnitTb.sv
